/* filelist.f */
+incdir+rtl
+incdir+verif
rtl/instrDecodePkg.sv
rtl/decodeClassBus.sv
rtl/opcodeClassifier.sv
rtl/operandRouter.sv
rtl/immediateGen.sv
rtl/instrDecoder.sv
verif/instrDecoderTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module instrDecoderTb -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output="$(./obj_dir/simv)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

/* verif/decodeModel.svh */
//----------------------------
// reference decode of the kept table
// needs instrDecodePkg enum values
//----------------------------
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
	logic valid;
	logic [`REG_ID_W-1:0] regN;
	logic [`REG_ID_W-1:0] regM;
	logic [`REG_ID_W-1:0] regO;
	logic [`IMM_W-1:0] imm;
	logic [7:0] uCmd;
	logic [7:0] uIxt;
} expectT;

// register id from a nibble and its extension bit
function automatic logic [5:0] regField(input logic [3:0] nib, input logic ext);
	logic special;
	special = (nib < 4'd2) || (nib == 4'hF);
	return {special, ext, nib};
endfunction

// fill bits from position width upward
function automatic logic [32:0] widen(input logic [32:0] v, input int width, input logic fill);
	logic [32:0] r;
	r = v;
	for (int i = width; i < 33; i++)
		r[i] = fill;
	return r;
endfunction

function automatic expectT expectedDecode(input logic [31:0] w, input logic v);
	expectT e;
	logic [3:0] op, hi, lo, oNib;
	logic q, rz, r1, ro1, fill, quadImm;
	logic [5:0] uc, ix, fm, n, m, o, alt, base;
	logic [3:0] ity;
	logic [2:0] bty;
	logic [1:0] cd;
	logic [3:0] cmp;
	op = w[11:8];
	hi = w[31:28];
	lo = w[19:16];
	oNib = w[23:20];
	q = w[27];
	uc = instrDecodePkg::UCMD_INVOP;
	fm = instrDecodePkg::FMID_INV;
	ity = instrDecodePkg::ITY_SB;
	bty = instrDecodePkg::BTY_SB;
	cd = instrDecodePkg::IXC_AL;
	ix = 6'h00;
	if (op == 4'h0 || op == 4'h4) begin
		if (hi == 4'h0 && lo[3:2] == 2'b01) begin
			uc = q ? instrDecodePkg::UCMD_LEA_MR : instrDecodePkg::UCMD_MOV_RM;
			fm = q ? instrDecodePkg::FMID_LDDRREGREG : instrDecodePkg::FMID_REGSTDRREG;
			ity = instrDecodePkg::ITY_UB;
			bty = {1'b0, lo[1:0]};
		end else if (hi == 4'h0 && lo[3:2] == 2'b11) begin
			uc = instrDecodePkg::UCMD_MOV_MR;
			fm = instrDecodePkg::FMID_LDDRREGREG;
			ity = instrDecodePkg::ITY_UB;
			bty = !q ? {1'b0, lo[1:0]} : (lo[1:0] == 2'd3 ? 3'd2 : 3'd4 + lo[1:0]);
		end else if (hi == 4'h1 && lo inside {4'h0, 4'h1, 4'h5, 4'h6, 4'h7}) begin
			uc = instrDecodePkg::UCMD_ALU3;
			fm = instrDecodePkg::FMID_REGREG;
			ix = lo[2:0];
		end else if (hi == 4'h1 && lo == 4'h2) begin
			uc = instrDecodePkg::UCMD_MUL3;
			fm = instrDecodePkg::FMID_REGREG;
			ix = 6'h20;
		end else if (hi == 4'h1 && lo == 4'h9) begin
			fm = instrDecodePkg::FMID_REGREG;
			ity = instrDecodePkg::ITY_NB;
			if (oNib inside {4'h4, 4'hC, 4'hD, 4'hE}) begin
				uc = instrDecodePkg::UCMD_ALUCMP;
				ix = {1'b0, q, oNib};
			end else if (oNib < 4'h8) begin
				uc = instrDecodePkg::UCMD_ALU3;
				ix = oNib[2:0];
			end else if (oNib == 4'h8) begin
				uc = instrDecodePkg::UCMD_CONV_RR;
				ity = instrDecodePkg::ITY_SB;
				ix = 6'h30;
			end else if (oNib == 4'h9 || oNib == 4'hF) begin
				uc = instrDecodePkg::UCMD_MUL3;
				ix = (oNib == 4'h9) ? 6'h21 : 6'h22;
			end else begin
				fm = instrDecodePkg::FMID_INV;
			end
		end else if (hi == 4'h5 && (lo == 4'h4 || lo == 4'h5)) begin
			fm = instrDecodePkg::FMID_REGREG;
			if (lo == 4'h4)
				uc = q ? instrDecodePkg::UCMD_SHADQ3 : instrDecodePkg::UCMD_SHAD3;
			else
				uc = q ? instrDecodePkg::UCMD_SHLDQ3 : instrDecodePkg::UCMD_SHLD3;
		end else if (hi == 4'h5 && (lo == 4'hC || lo == 4'hD)) begin
			uc = instrDecodePkg::UCMD_ALU3;
			fm = instrDecodePkg::FMID_REGREG;
			ix = 6'h08 + (q ? 6'h10 : 6'h00) + lo[0];
		end else if (hi[3:2] == 2'b11) begin
			uc = (hi == 4'hD) ? instrDecodePkg::UCMD_BSR : instrDecodePkg::UCMD_BRA;
			fm = instrDecodePkg::FMID_PCDISP8;
			ity = instrDecodePkg::ITY_SW;
			bty = instrDecodePkg::BTY_SW;
			if (hi == 4'hE)
				cd = instrDecodePkg::IXC_CT;
			else if (hi == 4'hF)
				cd = instrDecodePkg::IXC_CF;
		end
	end else if (op == 4'h1 || op == 4'h5) begin
		ity = instrDecodePkg::ITY_SW;
		if (hi[3:2] == 2'b00) begin
			uc = q ? instrDecodePkg::UCMD_LEA_MR : instrDecodePkg::UCMD_MOV_RM;
			fm = q ? instrDecodePkg::FMID_LDREGDISPREG : instrDecodePkg::FMID_REGSTREGDISP;
			bty = {1'b0, hi[1:0]};
		end else if (hi[3:2] == 2'b10) begin
			uc = instrDecodePkg::UCMD_MOV_MR;
			fm = instrDecodePkg::FMID_LDREGDISPREG;
			bty = !q ? {1'b0, hi[1:0]} : (hi[1:0] == 2'd3 ? 3'd6 : 3'd4 + hi[1:0]);
		end
	end else if (op == 4'h2 || op == 4'h6) begin
		fm = instrDecodePkg::FMID_REGIMMREG;
		ity = (hi == 4'h1 || hi == 4'h4) ? instrDecodePkg::ITY_NW : instrDecodePkg::ITY_UW;
		if (hi inside {4'h0, 4'h1, 4'h5, 4'h6, 4'h7}) begin
			uc = instrDecodePkg::UCMD_ALU3;
			ix = (hi == 4'h1) ? 6'h00 : hi[2:0];
		end else if (hi == 4'h2) begin
			uc = instrDecodePkg::UCMD_MUL3;
			ix = 6'h20;
		end else if (hi == 4'h3 || hi == 4'h4) begin
			uc = instrDecodePkg::UCMD_ALU3;
			ix = q ? 6'h18 : 6'h08;
		end else if (hi == 4'h8) begin
			uc = q ? instrDecodePkg::UCMD_SHADQ3 : instrDecodePkg::UCMD_SHAD3;
		end else if (hi == 4'h9) begin
			uc = q ? instrDecodePkg::UCMD_SHLDQ3 : instrDecodePkg::UCMD_SHLD3;
		end else if (hi == 4'hC) begin
			fm = instrDecodePkg::FMID_IMM8REG;
			ity = w[0] ? instrDecodePkg::ITY_NQ : instrDecodePkg::ITY_UQ;
			case (w[3:1])
				3'd2: cmp = 4'h4;
				3'd3: cmp = 4'hA;
				3'd4: cmp = 4'hD;
				3'd5: cmp = 4'hB;
				3'd6: cmp = 4'hC;
				default: cmp = 4'hE;
			endcase
			if (w[3:1] == 3'd0) begin
				uc = instrDecodePkg::UCMD_MOV_IR;
			end else if (w[3:1] == 3'd1) begin
				fm = instrDecodePkg::FMID_INV;
			end else begin
				uc = instrDecodePkg::UCMD_ALUCMP;
				ix = {1'b0, q, cmp};
			end
		end else begin
			fm = instrDecodePkg::FMID_INV;
		end
	end else if (op == 4'h8 || op == 4'h9) begin
		fm = instrDecodePkg::FMID_IMM8REG;
		uc = instrDecodePkg::UCMD_MOV_IR;
		ix = 6'h38;
		case (w[7:5])
			3'd0: ity = instrDecodePkg::ITY_UW;
			3'd1: ity = instrDecodePkg::ITY_NW;
			3'd2: begin
				uc = instrDecodePkg::UCMD_ALU3;
				ix = 6'h00;
			end
			3'd3: begin
				ity = instrDecodePkg::ITY_UB;
				ix = 6'h39;
			end
			default: begin
				uc = instrDecodePkg::UCMD_INVOP;
				fm = instrDecodePkg::FMID_INV;
			end
		endcase
	end else if (op == 4'hA || op == 4'hB) begin
		uc = instrDecodePkg::UCMD_MOV_IR;
		fm = w[8] ? instrDecodePkg::FMID_IMM12N : instrDecodePkg::FMID_IMM12Z;
		ix = 6'h38;
	end
	if (w[15:13] != 3'b111)
		fm = instrDecodePkg::FMID_Z;
	// base register flags
	rz = (w[25] == 1'b0) && (w[3:1] == 3'd0);
	r1 = rz && w[0];
	ro1 = (w[24] == 1'b0) && (oNib == 4'h1);
	n = regField(w[7:4], w[26]);
	m = regField(w[3:0], w[25]);
	o = regField(oNib, w[24]);
	alt = {m[5], w[4], w[3:0]};
	base = !rz ? m : (r1 ? `GR_GBR : `GR_PC);
	fill = (ity inside {instrDecodePkg::ITY_NB, instrDecodePkg::ITY_NW,
		instrDecodePkg::ITY_NQ});
	quadImm = (ity == instrDecodePkg::ITY_UQ) || (ity == instrDecodePkg::ITY_NQ);
	e.valid = v;
	e.uCmd = {cd, uc};
	e.uIxt = {cd, ix};
	e.regN = `GR_ZZR;
	e.regM = `GR_ZZR;
	e.regO = `GR_ZZR;
	e.imm = '0;
	case (fm)
		instrDecodePkg::FMID_Z, instrDecodePkg::FMID_INV: e.uIxt = 8'h00;
		instrDecodePkg::FMID_REGREG: begin
			e.regN = n;
			e.regM = (ity == instrDecodePkg::ITY_NB) ? n : m;
			e.regO = (ity == instrDecodePkg::ITY_NB) ? m :
				(ity == instrDecodePkg::ITY_UB) ? n : o;
			e.imm = w[4:0];
		end
		instrDecodePkg::FMID_REGIMMREG, instrDecodePkg::FMID_LDREGDISPREG,
		instrDecodePkg::FMID_REGSTREGDISP: begin
			e.regN = n;
			e.regM = (fm == instrDecodePkg::FMID_REGIMMREG) ? m : base;
			e.regO = `GR_IMM;
			fill = fill || (ity == instrDecodePkg::ITY_SW && w[24]);
			e.imm = widen(w[24:16], 9, fill);
		end
		instrDecodePkg::FMID_LDDRREGREG, instrDecodePkg::FMID_REGSTDRREG: begin
			e.regN = n;
			e.regM = base;
			e.regO = o;
			if (rz && ro1) begin
				e.regM = r1 ? `GR_TBR : `GR_DLR;
				e.regO = r1 ? `GR_DLR : `GR_ZZR;
			end
		end
		instrDecodePkg::FMID_IMM8REG: begin
			e.regO = `GR_IMM;
			if (quadImm) begin
				e.regN = n;
				e.regM = n;
				e.imm = widen(w[25:16], 10, fill);
			end else begin
				e.regN = alt;
				e.regM = (ity == instrDecodePkg::ITY_SB || ity == instrDecodePkg::ITY_UB) ?
					alt : `GR_IMM;
				if (e.regM == `GR_IMM)
					e.regO = alt;
				fill = fill || (ity == instrDecodePkg::ITY_SB && w[31]);
				e.imm = widen(w[31:16], 16, fill);
			end
		end
		instrDecodePkg::FMID_PCDISP8: begin
			e.regN = `GR_DLR;
			e.regM = `GR_PC;
			e.regO = `GR_IMM;
			e.imm = widen({w[7:0], w[27:16]}, 20, w[7]);
		end
		default: begin
			e.regN = `GR_DLR;
			e.regM = `GR_DLR;
			e.regO = `GR_IMM;
			e.imm = widen({w[7:0], w[31:16]}, 24, fm == instrDecodePkg::FMID_IMM12N);
		end
	endcase
	// memory forms carry the access size
	// a zero base drops the low size bits
	if (fm inside {instrDecodePkg::FMID_PCDISP8, instrDecodePkg::FMID_LDREGDISPREG,
			instrDecodePkg::FMID_REGSTREGDISP, instrDecodePkg::FMID_LDDRREGREG,
			instrDecodePkg::FMID_REGSTDRREG}) begin
		e.uIxt = {cd, bty[1:0], 1'b1, bty};
		if (rz && fm != instrDecodePkg::FMID_PCDISP8)
			e.uIxt[1:0] = 2'b00;
	end
	return e;
endfunction

`endif

/* verif/instrDecoderTb.sv */
//----------------------------
// random words from seed 22264
//----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "instrDecode_config.svh"

module instrDecoderTb;

	`include "decodeModel.svh"

	localparam int WORDS = 400;
	// five word tests plus reset and margin
	localparam int CYCLE_LIMIT = 5 * WORDS + 400;

	logic clock;
	logic rstN;
	logic [`ISTR_W-1:0] istrWord;
	logic istrValid;
	logic idValid;
	logic [`REG_ID_W-1:0] idRegN;
	logic [`REG_ID_W-1:0] idRegM;
	logic [`REG_ID_W-1:0] idRegO;
	logic [`IMM_W-1:0] idImm;
	logic [7:0] idUCmd;
	logic [7:0] idUIxt;

	expectT pending[$];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int testErrors;

	instrDecoder i_instrDecoder (
		.clock(clock),
		.rstN(rstN),
		.istrWord(istrWord),
		.istrValid(istrValid),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing the tests", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic reportValue(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("error %0t %s expected %h got %h", $time, name, exp, got);
		errors++;
	endtask

	task automatic compareOutputs(input expectT e);
		checks++;
		assert (idValid === e.valid) else reportValue("idValid", e.valid, idValid);
		assert (idRegN === e.regN) else reportValue("idRegN", e.regN, idRegN);
		assert (idRegM === e.regM) else reportValue("idRegM", e.regM, idRegM);
		assert (idRegO === e.regO) else reportValue("idRegO", e.regO, idRegO);
		assert (idImm === e.imm) else reportValue("idImm", e.imm, idImm);
		assert (idUCmd === e.uCmd) else reportValue("idUCmd", e.uCmd, idUCmd);
		assert (idUIxt === e.uIxt) else reportValue("idUIxt", e.uIxt, idUIxt);
	endtask

	// check the previous word then drive the next one
	task automatic stepWord(input logic [31:0] w, input logic v);
		@(posedge clock);
		#1;
		if (pending.size() > 0)
			compareOutputs(pending.pop_front());
		istrWord = w;
		istrValid = v;
		pending.push_back(expectedDecode(w, v));
	endtask

	function automatic logic [31:0] makeWord(input int test);
		logic [31:0] w;
		int pick;
		w = $urandom;
		w[15:13] = 3'b111;
		pick = $urandom % 8;
		case (test)
			2: begin
				w[11:8] = {1'b0, w[10], 2'b00};
				case (pick)
					0, 1: w[31:28] = 4'h1;
					2: {w[31:28], w[19:16]} = 8'h12;
					3, 4: {w[31:28], w[19:16]} = 8'h19;
					default: {w[31:28], w[19:16]} = {4'h5, w[17] ? 4'h4 : 4'hC};
				endcase
				if (w[31:28] == 4'h1 && pick < 2)
					w[19:16] = (pick == 0) ? {1'b0, w[18:16]} : 4'h1;
				if (w[31:28] == 4'h5)
					w[16] = $urandom;
			end
			3: begin
				if (pick < 4) begin
					w[11:8] = {1'b0, w[10], 2'b00};
					w[31:28] = 4'h0;
					w[19:18] = {w[19], 1'b1};
				end else begin
					w[11:8] = {1'b0, w[10], 2'b01};
					w[31:30] = {w[31], 1'b0};
				end
				// bias towards R0 and R1 bases and an R1 index
				if (pick[0])
					{w[25], w[3:1]} = 4'b0000;
				if (pick[1])
					{w[24], w[23:20]} = 5'b00001;
			end
			4: begin
				if (pick < 4) begin
					w[11:8] = {1'b0, w[10], 2'b10};
					w[31:28] = (pick == 0) ? 4'hC : $urandom % 10;
				end else if (pick < 6) begin
					w[11:8] = {3'b100, w[8]};
				end else begin
					w[11:8] = {3'b101, w[8]};
				end
			end
			5: begin
				w[11:8] = {1'b0, w[10], 2'b00};
				w[31:30] = 2'b11;
			end
			default: begin
				if (pick < 3)
					w[15:13] = $urandom % 7;
			end
		endcase
		return w;
	endfunction

	task automatic runWords(input int test, input string name);
		testErrors = errors;
		for (int i = 0; i < WORDS; i++) begin
			if (test == 6 && i >= WORDS / 2)
				stepWord(makeWord(test), 1'b1);
			else
				stepWord(makeWord(test), $urandom % 2);
		end
		$display("test %0d %s: %0d words, %0d errors", test, name, WORDS, errors - testErrors);
	endtask

	initial begin
		void'($urandom(22264));
		rstN = 1'b0;
		istrWord = '0;
		istrValid = 1'b1;
		// reset held for 10 cycles with idle outputs
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			#1;
			checks++;
			assert (idValid === 1'b0) else reportValue("idValid", 0, idValid);
			assert (idUCmd === {instrDecodePkg::IXC_AL, instrDecodePkg::UCMD_NOP})
				else reportValue("idUCmd", {instrDecodePkg::IXC_AL, instrDecodePkg::UCMD_NOP},
					idUCmd);
		end
		rstN = 1'b1;
		pending.push_back(expectedDecode(istrWord, istrValid));
		$display("test 1 reset: %0d errors", errors);
		runWords(2, "register ALU and shifts");
		runWords(3, "loads and stores");
		runWords(4, "immediate forms");
		runWords(5, "branches");
		runWords(6, "random words");
		@(posedge clock);
		#1;
		if (pending.size() > 0)
			compareOutputs(pending.pop_front());
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/instrDecoder.sv */
//----------------------------
// one-stage decoder, no stall
//----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "instrDecode_config.svh"

module instrDecoder (
	input wire clock,
	input wire rstN,
	input wire [`ISTR_W-1:0] istrWord,
	input wire istrValid,
	output logic idValid,
	output logic [`REG_ID_W-1:0] idRegN,
	output logic [`REG_ID_W-1:0] idRegM,
	output logic [`REG_ID_W-1:0] idRegO,
	output logic [`IMM_W-1:0] idImm,
	output logic [7:0] idUCmd,
	output logic [7:0] idUIxt
);

	decodeClassBus cls ();

	opcodeClassifier i_opcodeClassifier (
		.clock(clock),
		.rstN(rstN),
		.istrWord(istrWord),
		.istrValid(istrValid),
		.cls(cls.ctrl),
		.idValid(idValid),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt)
	);

	operandRouter i_operandRouter (
		.clock(clock),
		.rstN(rstN),
		.istrWord(istrWord),
		.cls(cls.dp),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO)
	);

	immediateGen i_immediateGen (
		.clock(clock),
		.rstN(rstN),
		.istrWord(istrWord),
		.cls(cls.dp),
		.idImm(idImm)
	);

endmodule

`default_nettype wire

/* rtl/immediateGen.sv */
//----------------------------
// fill widths assume IMM_W of 33
//----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "instrDecode_config.svh"

module immediateGen (
	input wire clock,
	input wire rstN,
	input wire [`ISTR_W-1:0] istrWord,
	decodeClassBus.dp cls,
	output logic [`IMM_W-1:0] idImm
);

	// N types fill with ones and S types with the sign bit
	function automatic logic fillBit(input instrDecodePkg::immTypeT ity, input logic signBit);
		logic fill;
		case (ity)
			instrDecodePkg::ITY_NB, instrDecodePkg::ITY_NW, instrDecodePkg::ITY_NQ: fill = 1'b1;
			instrDecodePkg::ITY_SB, instrDecodePkg::ITY_SW: fill = signBit;
			default: fill = 1'b0;
		endcase
		return fill;
	endfunction

	logic [`IMM_W-1:0] imm17;
	logic [`IMM_W-1:0] imm10;
	logic [`IMM_W-1:0] imm16;
	logic [`IMM_W-1:0] disp20;
	logic [`IMM_W-1:0] const24;
	logic [`IMM_W-1:0] immNext;

	assign imm17 = {{24{fillBit(cls.immType, istrWord[24])}}, istrWord[24:16]};
	assign imm10 = {{23{fillBit(cls.immType, istrWord[25])}}, istrWord[25:16]};
	assign imm16 = {{17{fillBit(cls.immType, istrWord[31])}}, istrWord[31:16]};
	// branch displacement is always signed
	assign disp20 = {{13{istrWord[7]}}, istrWord[7:0], istrWord[27:16]};
	assign const24 = {{9{cls.form == instrDecodePkg::FMID_IMM12N}}, istrWord[7:0],
		istrWord[31:16]};

	always_comb begin
		case (cls.form)
			instrDecodePkg::FMID_REGREG: immNext = {{(`IMM_W-5){1'b0}}, istrWord[4:0]};
			instrDecodePkg::FMID_REGIMMREG, instrDecodePkg::FMID_LDREGDISPREG,
			instrDecodePkg::FMID_REGSTREGDISP: immNext = imm17;
			instrDecodePkg::FMID_IMM8REG: begin
				if (cls.immType == instrDecodePkg::ITY_UQ || cls.immType == instrDecodePkg::ITY_NQ)
					immNext = imm10;
				else
					immNext = imm16;
			end
			instrDecodePkg::FMID_PCDISP8: immNext = disp20;
			instrDecodePkg::FMID_IMM12Z, instrDecodePkg::FMID_IMM12N: immNext = const24;
			default: immNext = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN)
			idImm <= '0;
		else
			idImm <= immNext;
	end

endmodule

`default_nettype wire

/* rtl/operandRouter.sv */
//----------------------------
// register ids by operand form
//----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "instrDecode_config.svh"

module operandRouter (
	input wire clock,
	input wire rstN,
	input wire [`ISTR_W-1:0] istrWord,
	decodeClassBus.dp cls,
	output logic [`REG_ID_W-1:0] idRegN,
	output logic [`REG_ID_W-1:0] idRegM,
	output logic [`REG_ID_W-1:0] idRegO
);

	// special flag marks R0, R1 and R15 style nibbles
	function automatic logic [`REG_ID_W-1:0] fieldId(input logic [3:0] nib, input logic ext);
		return {(nib[3:1] == 3'b000) || (nib == 4'hF), ext, nib};
	endfunction

	logic [`REG_ID_W-1:0] regN;
	logic [`REG_ID_W-1:0] regM;
	logic [`REG_ID_W-1:0] regO;
	logic [`REG_ID_W-1:0] regAlt;
	logic [`REG_ID_W-1:0] baseM;
	logic [`REG_ID_W-1:0] nextN;
	logic [`REG_ID_W-1:0] nextM;
	logic [`REG_ID_W-1:0] nextO;

	assign regN = fieldId(istrWord[7:4], istrWord[26]);
	assign regM = fieldId(istrWord[3:0], istrWord[25]);
	assign regO = fieldId(istrWord[23:20], istrWord[24]);
	// IMM8REG register in the low byte with bit 4 as extension
	assign regAlt = {regM[5], istrWord[4], istrWord[3:0]};
	// R1 base selects GBR and R0 base selects PC
	assign baseM = cls.rmIsRz ? (cls.rmIsR1 ? `GR_GBR : `GR_PC) : regM;

	always_comb begin
		nextN = `GR_ZZR;
		nextM = `GR_ZZR;
		nextO = `GR_ZZR;
		case (cls.form)
			instrDecodePkg::FMID_REGREG: begin
				nextN = regN;
				nextM = (cls.immType == instrDecodePkg::ITY_NB) ? regN : regM;
				if (cls.immType == instrDecodePkg::ITY_NB)
					nextO = regM;
				else if (cls.immType == instrDecodePkg::ITY_UB)
					nextO = regN;
				else
					nextO = regO;
			end
			instrDecodePkg::FMID_REGIMMREG: begin
				nextN = regN;
				nextM = regM;
				nextO = `GR_IMM;
			end
			instrDecodePkg::FMID_LDREGDISPREG, instrDecodePkg::FMID_REGSTREGDISP: begin
				nextN = regN;
				nextM = baseM;
				nextO = `GR_IMM;
			end
			instrDecodePkg::FMID_LDDRREGREG, instrDecodePkg::FMID_REGSTDRREG: begin
				nextN = regN;
				nextM = baseM;
				nextO = regO;
				// R1 index on a zero base picks the TBR or DLR pair
				if (cls.rmIsRz && cls.roIsR1) begin
					nextM = cls.rmIsR1 ? `GR_TBR : `GR_DLR;
					nextO = cls.rmIsR1 ? `GR_DLR : `GR_ZZR;
				end
			end
			instrDecodePkg::FMID_IMM8REG: begin
				case (cls.immType)
					instrDecodePkg::ITY_UQ, instrDecodePkg::ITY_NQ: begin
						nextN = regN;
						nextM = regN;
						nextO = `GR_IMM;
					end
					instrDecodePkg::ITY_SB, instrDecodePkg::ITY_UB: begin
						nextN = regAlt;
						nextM = regAlt;
						nextO = `GR_IMM;
					end
					default: begin
						nextN = regAlt;
						nextM = `GR_IMM;
						nextO = regAlt;
					end
				endcase
			end
			instrDecodePkg::FMID_PCDISP8: begin
				nextN = `GR_DLR;
				nextM = `GR_PC;
				nextO = `GR_IMM;
			end
			instrDecodePkg::FMID_IMM12Z, instrDecodePkg::FMID_IMM12N: begin
				nextN = `GR_DLR;
				nextM = `GR_DLR;
				nextO = `GR_IMM;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			idRegN <= `GR_ZZR;
			idRegM <= `GR_ZZR;
			idRegO <= `GR_ZZR;
		end else begin
			idRegN <= nextN;
			idRegM <= nextM;
			idRegO <= nextO;
		end
	end

endmodule

`default_nettype wire

/* rtl/opcodeClassifier.sv */
//----------------------------
// 32-bit forms only, no FPU ops
// outputs one cycle after the word
//----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "instrDecode_config.svh"

module opcodeClassifier (
	input wire clock,
	input wire rstN,
	input wire [`ISTR_W-1:0] istrWord,
	input wire istrValid,
	decodeClassBus.ctrl cls,
	output logic idValid,
	output logic [7:0] idUCmd,
	output logic [7:0] idUIxt
);

	// load size per low opcode bits, the size-3 slot differs between blocks
	function automatic instrDecodePkg::accessT loadSize(input logic [1:0] sel,
			input logic q, input instrDecodePkg::accessT qSize3);
		instrDecodePkg::accessT size;
		case (sel)
			2'd0: size = q ? instrDecodePkg::BTY_UB : instrDecodePkg::BTY_SB;
			2'd1: size = q ? instrDecodePkg::BTY_UW : instrDecodePkg::BTY_SW;
			2'd2: size = q ? instrDecodePkg::BTY_UL : instrDecodePkg::BTY_SL;
			default: size = q ? qSize3 : instrDecodePkg::BTY_SQ;
		endcase
		return size;
	endfunction

	// low nibble of the compare sub-op for the F2 immediate compares
	function automatic logic [3:0] cmpOp(input logic [2:0] sel);
		logic [3:0] op;
		case (sel)
			3'd2: op = 4'h4;
			3'd3: op = 4'hA;
			3'd4: op = 4'hD;
			3'd5: op = 4'hB;
			3'd6: op = 4'hC;
			default: op = 4'hE;
		endcase
		return op;
	endfunction

	logic qBit;
	instrDecodePkg::uCmdT uCmd;
	instrDecodePkg::formT form;
	instrDecodePkg::immTypeT ity;
	instrDecodePkg::accessT bty;
	instrDecodePkg::condT cond;
	instrDecodePkg::uCmdIxT ix;
	logic [7:0] memIxt;
	logic [7:0] memIxtZ;
	logic [7:0] uIxtNext;

	assign qBit = istrWord[27];

	always_comb begin
		uCmd = instrDecodePkg::UCMD_INVOP;
		form = instrDecodePkg::FMID_INV;
		ity = instrDecodePkg::ITY_SB;
		bty = instrDecodePkg::BTY_SB;
		cond = instrDecodePkg::IXC_AL;
		ix = instrDecodePkg::UCIX_ALU_ADD;
		casez (istrWord[11:8])
			4'b0z00: begin
				// F0 block keyed by the top nibble and the low opcode nibble
				casez ({istrWord[31:28], istrWord[19:16]})
					8'b0000_01zz: begin
						uCmd = qBit ? instrDecodePkg::UCMD_LEA_MR : instrDecodePkg::UCMD_MOV_RM;
						form = qBit ? instrDecodePkg::FMID_LDDRREGREG :
							instrDecodePkg::FMID_REGSTDRREG;
						ity = instrDecodePkg::ITY_UB;
						bty = instrDecodePkg::accessT'({1'b0, istrWord[17:16]});
					end
					8'b0000_11zz: begin
						uCmd = instrDecodePkg::UCMD_MOV_MR;
						form = instrDecodePkg::FMID_LDDRREGREG;
						ity = instrDecodePkg::ITY_UB;
						bty = loadSize(istrWord[17:16], qBit, instrDecodePkg::BTY_SL);
					end
					8'h10, 8'h11, 8'h15, 8'h16, 8'h17: begin
						uCmd = instrDecodePkg::UCMD_ALU3;
						form = instrDecodePkg::FMID_REGREG;
						ix = instrDecodePkg::uCmdIxT'({3'b000, istrWord[18:16]});
					end
					8'h12: begin
						uCmd = instrDecodePkg::UCMD_MUL3;
						form = instrDecodePkg::FMID_REGREG;
						ix = instrDecodePkg::UCIX_MUL3_MUL3S;
					end
					8'h19: begin
						// 1ez9 group selected by the O nibble
						form = instrDecodePkg::FMID_REGREG;
						ity = instrDecodePkg::ITY_NB;
						case (istrWord[23:20])
							4'h0, 4'h1, 4'h2, 4'h3, 4'h5, 4'h6, 4'h7: begin
								uCmd = instrDecodePkg::UCMD_ALU3;
								ix = instrDecodePkg::uCmdIxT'({3'b000, istrWord[22:20]});
							end
							4'h4, 4'hC, 4'hD, 4'hE: begin
								uCmd = instrDecodePkg::UCMD_ALUCMP;
								ix = instrDecodePkg::uCmdIxT'({1'b0, qBit, istrWord[23:20]});
							end
							4'h8: begin
								uCmd = instrDecodePkg::UCMD_CONV_RR;
								ity = instrDecodePkg::ITY_SB;
								ix = instrDecodePkg::UCIX_CONV_MOV;
							end
							4'h9: begin
								uCmd = instrDecodePkg::UCMD_MUL3;
								ix = instrDecodePkg::UCIX_MUL3_MULS;
							end
							4'hF: begin
								uCmd = instrDecodePkg::UCMD_MUL3;
								ix = instrDecodePkg::UCIX_MUL3_MULU;
							end
							default: begin
								form = instrDecodePkg::FMID_INV;
							end
						endcase
					end
					8'h54: begin
						uCmd = qBit ? instrDecodePkg::UCMD_SHADQ3 : instrDecodePkg::UCMD_SHAD3;
						form = instrDecodePkg::FMID_REGREG;
					end
					8'h55: begin
						uCmd = qBit ? instrDecodePkg::UCMD_SHLDQ3 : instrDecodePkg::UCMD_SHLD3;
						form = instrDecodePkg::FMID_REGREG;
					end
					8'h5C, 8'h5D: begin
						uCmd = instrDecodePkg::UCMD_ALU3;
						form = instrDecodePkg::FMID_REGREG;
						ix = instrDecodePkg::uCmdIxT'({1'b0, qBit, 3'b100, istrWord[16]});
					end
					8'b11zz_zzzz: begin
						// Cddd BRA, Dddd BSR, Eddd BT, Fddd BF
						uCmd = (istrWord[29:28] == 2'b01) ? instrDecodePkg::UCMD_BSR :
							instrDecodePkg::UCMD_BRA;
						form = instrDecodePkg::FMID_PCDISP8;
						ity = instrDecodePkg::ITY_SW;
						bty = instrDecodePkg::BTY_SW;
						if (istrWord[29:28] == 2'b10)
							cond = instrDecodePkg::IXC_CT;
						else if (istrWord[29:28] == 2'b11)
							cond = instrDecodePkg::IXC_CF;
					end
					default: begin
						form = instrDecodePkg::FMID_INV;
					end
				endcase
			end
			4'b0z01: begin
				// F1 displacement loads and stores
				ity = instrDecodePkg::ITY_SW;
				casez (istrWord[31:28])
					4'b00zz: begin
						uCmd = qBit ? instrDecodePkg::UCMD_LEA_MR : instrDecodePkg::UCMD_MOV_RM;
						form = qBit ? instrDecodePkg::FMID_LDREGDISPREG :
							instrDecodePkg::FMID_REGSTREGDISP;
						bty = instrDecodePkg::accessT'({1'b0, istrWord[29:28]});
					end
					4'b10zz: begin
						uCmd = instrDecodePkg::UCMD_MOV_MR;
						form = instrDecodePkg::FMID_LDREGDISPREG;
						bty = loadSize(istrWord[29:28], qBit, instrDecodePkg::BTY_UL);
					end
					default: begin
						form = instrDecodePkg::FMID_INV;
					end
				endcase
			end
			4'b0z10: begin
				// F2 immediate ALU, shift and compare
				form = instrDecodePkg::FMID_REGIMMREG;
				ity = instrDecodePkg::ITY_UW;
				case (istrWord[31:28])
					4'h0, 4'h1, 4'h5, 4'h6, 4'h7: begin
						uCmd = instrDecodePkg::UCMD_ALU3;
						if (istrWord[31:28] == 4'h1)
							ity = instrDecodePkg::ITY_NW;
						else
							ix = instrDecodePkg::uCmdIxT'({3'b000, istrWord[30:28]});
					end
					4'h2: begin
						uCmd = instrDecodePkg::UCMD_MUL3;
						ix = instrDecodePkg::UCIX_MUL3_MUL3S;
					end
					4'h3, 4'h4: begin
						uCmd = instrDecodePkg::UCMD_ALU3;
						ix = instrDecodePkg::uCmdIxT'({1'b0, qBit, 4'h8});
						if (istrWord[31:28] == 4'h4)
							ity = instrDecodePkg::ITY_NW;
					end
					4'h8: uCmd = qBit ? instrDecodePkg::UCMD_SHADQ3 : instrDecodePkg::UCMD_SHAD3;
					4'h9: uCmd = qBit ? instrDecodePkg::UCMD_SHLDQ3 : instrDecodePkg::UCMD_SHLD3;
					4'hC: begin
						form = instrDecodePkg::FMID_IMM8REG;
						ity = istrWord[0] ? instrDecodePkg::ITY_NQ : instrDecodePkg::ITY_UQ;
						if (istrWord[3:1] == 3'b000) begin
							uCmd = instrDecodePkg::UCMD_MOV_IR;
						end else if (istrWord[3:1] == 3'b001) begin
							form = instrDecodePkg::FMID_INV;
						end else begin
							uCmd = instrDecodePkg::UCMD_ALUCMP;
							ix = instrDecodePkg::uCmdIxT'({1'b0, qBit, cmpOp(istrWord[3:1])});
						end
					end
					default: begin
						form = instrDecodePkg::FMID_INV;
					end
				endcase
			end
			4'b100z: begin
				// F8 16-bit immediate, op in bits 7:5
				form = instrDecodePkg::FMID_IMM8REG;
				uCmd = instrDecodePkg::UCMD_MOV_IR;
				ix = instrDecodePkg::UCIX_LDI_LDIX;
				case (istrWord[7:5])
					3'b000: ity = instrDecodePkg::ITY_UW;
					3'b001: ity = instrDecodePkg::ITY_NW;
					3'b010: begin
						uCmd = instrDecodePkg::UCMD_ALU3;
						ix = instrDecodePkg::UCIX_ALU_ADD;
					end
					3'b011: begin
						ity = instrDecodePkg::ITY_UB;
						ix = instrDecodePkg::UCIX_LDI_LDISH16;
					end
					default: begin
						uCmd = instrDecodePkg::UCMD_INVOP;
						form = instrDecodePkg::FMID_INV;
					end
				endcase
			end
			4'hA, 4'hB: begin
				uCmd = instrDecodePkg::UCMD_MOV_IR;
				form = istrWord[8] ? instrDecodePkg::FMID_IMM12N : instrDecodePkg::FMID_IMM12Z;
				ix = instrDecodePkg::UCIX_LDI_LDIX;
			end
			default: begin
				form = instrDecodePkg::FMID_INV;
			end
		endcase
	end

	// words outside the F prefix carry no operands
	assign cls.form = (istrWord[15:13] != 3'b111) ? instrDecodePkg::FMID_Z : form;
	assign cls.immType = ity;
	assign cls.access = bty;
	assign cls.cond = cond;
	assign cls.rmIsRz = ({istrWord[25], istrWord[3:1]} == 4'b0000);
	assign cls.rmIsR1 = cls.rmIsRz && istrWord[0];
	assign cls.roIsR1 = ({istrWord[24], istrWord[23:21]} == 4'b0000) && istrWord[20];

	assign memIxt = {cls.cond, cls.access[1:0], 1'b1, cls.access};
	// zero-base variant drops the low size bits
	assign memIxtZ = {cls.cond, cls.access[1:0], 1'b1, cls.access[2], 2'b00};

	always_comb begin
		case (cls.form)
			instrDecodePkg::FMID_Z, instrDecodePkg::FMID_INV: uIxtNext = '0;
			instrDecodePkg::FMID_PCDISP8: uIxtNext = memIxt;
			instrDecodePkg::FMID_LDREGDISPREG, instrDecodePkg::FMID_REGSTREGDISP,
			instrDecodePkg::FMID_LDDRREGREG, instrDecodePkg::FMID_REGSTDRREG:
				uIxtNext = cls.rmIsRz ? memIxtZ : memIxt;
			default: uIxtNext = {cls.cond, ix};
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			idValid <= 1'b0;
			idUCmd <= {instrDecodePkg::IXC_AL, instrDecodePkg::UCMD_NOP};
			idUIxt <= '0;
		end else begin
			idValid <= istrValid;
			idUCmd <= {cls.cond, uCmd};
			idUIxt <= uIxtNext;
		end
	end

endmodule

`default_nettype wire

/* rtl/decodeClassBus.sv */
//----------------------------
// combinational classification
//----------------------------
`timescale 1ns/1ps
`default_nettype none

interface decodeClassBus;
	instrDecodePkg::formT form;
	instrDecodePkg::immTypeT immType;
	instrDecodePkg::accessT access;
	instrDecodePkg::condT cond;
	// base register flags taken from the raw fields
	logic rmIsRz;
	logic rmIsR1;
	logic roIsR1;

	modport ctrl (
		output form, immType, access, cond, rmIsRz, rmIsR1, roIsR1
	);
	modport dp (
		input form, immType, access, cond, rmIsRz, rmIsR1, roIsR1
	);
endinterface

`default_nettype wire

/* rtl/instrDecodePkg.sv */
//----------------------------
// decode enums, values fixed
// the testbench model relies on them
//----------------------------
`default_nettype none

package instrDecodePkg;

	// major micro-op, low 6 bits of idUCmd
	typedef enum logic [5:0] {
		UCMD_INVOP, UCMD_NOP, UCMD_MOV_RM, UCMD_MOV_MR,
		UCMD_LEA_MR, UCMD_ALU3, UCMD_ALUCMP, UCMD_MUL3,
		UCMD_CONV_RR, UCMD_SHAD3, UCMD_SHADQ3, UCMD_SHLD3,
		UCMD_SHLDQ3, UCMD_MOV_IR, UCMD_BRA, UCMD_BSR
	} uCmdT;

	typedef enum logic [4:0] {
		FMID_Z, FMID_INV, FMID_REGREG, FMID_REGIMMREG,
		FMID_LDREGDISPREG, FMID_REGSTREGDISP, FMID_LDDRREGREG, FMID_REGSTDRREG,
		FMID_IMM8REG, FMID_PCDISP8, FMID_IMM12Z, FMID_IMM12N
	} formT;

	// immediate extension and operand order
	typedef enum logic [3:0] {
		ITY_SB, ITY_SW, ITY_UB, ITY_UW, ITY_NB, ITY_NW, ITY_UQ, ITY_NQ
	} immTypeT;

	typedef enum logic [2:0] {
		BTY_SB, BTY_SW, BTY_SL, BTY_SQ, BTY_UB, BTY_UW, BTY_UL
	} accessT;

	typedef enum logic [1:0] {
		IXC_AL, IXC_CT, IXC_CF
	} condT;

	// quad variants of ALU ops sit 0x10 above the plain ones
	typedef enum logic [5:0] {
		UCIX_ALU_ADD = 6'h00, UCIX_ALU_SUB = 6'h01, UCIX_ALU_ADC = 6'h02,
		UCIX_ALU_SBB = 6'h03, UCIX_ALU_TST = 6'h04, UCIX_ALU_AND = 6'h05,
		UCIX_ALU_OR = 6'h06, UCIX_ALU_XOR = 6'h07, UCIX_ALU_ADDSL = 6'h08,
		UCIX_ALU_SUBSL = 6'h09, UCIX_ALU_CMPHS = 6'h0A, UCIX_ALU_CMPGE = 6'h0B,
		UCIX_ALU_CMPEQ = 6'h0C, UCIX_ALU_CMPHI = 6'h0D, UCIX_ALU_CMPGT = 6'h0E,
		UCIX_ALU_TSTQ = 6'h14, UCIX_ALU_ADDUL = 6'h18, UCIX_ALU_SUBUL = 6'h19,
		UCIX_ALU_CMPQHS = 6'h1A, UCIX_ALU_CMPQGE = 6'h1B, UCIX_ALU_CMPQEQ = 6'h1C,
		UCIX_ALU_CMPQHI = 6'h1D, UCIX_ALU_CMPQGT = 6'h1E,
		UCIX_MUL3_MUL3S = 6'h20, UCIX_MUL3_MULS = 6'h21, UCIX_MUL3_MULU = 6'h22,
		UCIX_CONV_MOV = 6'h30,
		UCIX_LDI_LDIX = 6'h38, UCIX_LDI_LDISH16 = 6'h39
	} uCmdIxT;

endpackage

`default_nettype wire

/* rtl/instrDecode_config.svh */
//----------------------------
// decoder widths and fixed ids
// R0 field with no extension aliases DLR
//----------------------------
`ifndef INSTR_DECODE_CONFIG_SVH
`define INSTR_DECODE_CONFIG_SVH

`define ISTR_W   32
`define REG_ID_W 6
`define IMM_W    33

// ids outside the range that a register field can produce
`define GR_ZZR 6'h3D
`define GR_IMM 6'h3E
`define GR_DLR 6'h20
`define GR_PC  6'h22
`define GR_GBR 6'h23
`define GR_TBR 6'h24

`endif
